//--- dv/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Value that only skipped instructions ever store
localparam logic [31:0] poison = 32'hBAD0_D000;
localparam logic [31:0] poison_addr = 32'h0000_07F0;

// ------------------------------
// RV32I instruction encoders
// ------------------------------
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
endfunction

// SW only
function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
        input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
        input logic [19:0] upper);
    return {upper, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// ------------------------------
// Program building
// ------------------------------
function automatic logic [31:0] current_pc();
    return {23'd0, n_instr, 2'b00};
endfunction

task automatic emit(input logic [31:0] word);
    rom[n_instr] = word;
    n_instr = n_instr + 7'd1;
endtask

task automatic emit_poison();
    emit(s_type(5'd31, 5'd0, poison_addr));
endtask

task automatic expect_store(input logic [1:0] sect, input logic [31:0] addr,
        input logic [31:0] data);
    exp_sect.push_back(sect);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// Taken case skips a poison store and the not-taken case counts in x21
task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
        input logic [4:0] n1, input logic [4:0] n2);
    emit(b_type(f3, t1, t2, 32'd8));
    emit_poison();
    emit(b_type(f3, n1, n2, 32'd8));
    emit(i_type(7'h13, 3'b000, 5'd21, 5'd21, 32'd1));
endtask

task automatic load_program();
    logic [31:0] pc_auipc;
    logic [31:0] pc_jal;
    logic [31:0] pc_jalr;
    int          r;
    n_instr = 7'd0;
    // Store sits at the reset vector and is fetched all through reset
    emit(s_type(5'd0, 5'd0, 32'h13C));
    // Arithmetic with x1 = -7 and x2 = 3
    emit(u_type(7'h37, 5'd31, poison[31:12]));
    emit(i_type(7'h13, 3'b000, 5'd1, 5'd0, -32'd7));
    emit(i_type(7'h13, 3'b000, 5'd2, 5'd0, 32'd3));
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
    emit(r_type(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b111, 5'd7, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b001, 5'd8, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b101, 5'd9, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b101, 5'd10, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b010, 5'd11, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b011, 5'd12, 5'd1, 5'd2));
    emit(i_type(7'h13, 3'b010, 5'd13, 5'd1, -32'd8));
    emit(i_type(7'h13, 3'b011, 5'd14, 5'd2, -32'd1));
    emit(i_type(7'h13, 3'b101, 5'd15, 5'd1, 32'h401));
    emit(i_type(7'h13, 3'b111, 5'd16, 5'd1, 32'h0F0));
    emit(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
    for (r = 3; r <= 16; r++) begin
        emit(s_type(5'(r), 5'd0, 32'h100 + 4 * (r - 3)));
    end
    emit(s_type(5'd0, 5'd0, 32'h138));
    expect_store(2'd0, 32'h13C, 32'h0000_0000);  // written once, after reset
    expect_store(2'd0, 32'h100, 32'hFFFF_FFFC);  // add  -7 + 3
    expect_store(2'd0, 32'h104, 32'h0000_000A);  // sub  3 - (-7)
    expect_store(2'd0, 32'h108, 32'hFFFF_FFFA);  // xor
    expect_store(2'd0, 32'h10C, 32'hFFFF_FFFB);  // or
    expect_store(2'd0, 32'h110, 32'h0000_0001);  // and
    expect_store(2'd0, 32'h114, 32'hFFFF_FFC8);  // sll  -7 << 3 = -56
    expect_store(2'd0, 32'h118, 32'h1FFF_FFFF);  // srl zero fill
    expect_store(2'd0, 32'h11C, 32'hFFFF_FFFF);  // sra  floor(-7 / 8)
    expect_store(2'd0, 32'h120, 32'h0000_0001);  // slt  -7 < 3
    expect_store(2'd0, 32'h124, 32'h0000_0000);  // sltu 0xFFFFFFF9 < 3 is false
    expect_store(2'd0, 32'h128, 32'h0000_0000);  // slti -7 < -8 is false
    expect_store(2'd0, 32'h12C, 32'h0000_0001);  // sltiu 3 < 0xFFFFFFFF
    expect_store(2'd0, 32'h130, 32'hFFFF_FFFC);  // srai -7 >>> 1 = -4
    expect_store(2'd0, 32'h134, 32'h0000_00F0);  // andi 0xF9 & 0xF0
    expect_store(2'd0, 32'h138, 32'h0000_0000);  // x0 ignores the add
    // Upper immediates and jumps with every link at pc + 4
    emit(u_type(7'h37, 5'd1, 20'h12345));
    pc_auipc = current_pc();
    emit(u_type(7'h17, 5'd2, 20'h00001));
    pc_jal = current_pc();
    emit(j_type(5'd3, 32'd8));
    emit_poison();
    emit(u_type(7'h17, 5'd4, 20'h00000));
    pc_jalr = current_pc();
    // Odd offset 13 lands on x4 + 12 once bit 0 is cleared
    emit(i_type(7'h67, 3'b000, 5'd5, 5'd4, 32'd13));
    emit_poison();
    emit(s_type(5'd1, 5'd0, 32'h200));
    emit(s_type(5'd2, 5'd0, 32'h204));
    emit(s_type(5'd3, 5'd0, 32'h208));
    emit(s_type(5'd5, 5'd0, 32'h20C));
    expect_store(2'd1, 32'h200, 32'h1234_5000);
    expect_store(2'd1, 32'h204, pc_auipc + 32'h1000);
    expect_store(2'd1, 32'h208, pc_jal + 32'd4);
    expect_store(2'd1, 32'h20C, pc_jalr + 32'd4);
    // Branches with x6 = -2 and x7 = 5
    emit(i_type(7'h13, 3'b000, 5'd6, 5'd0, -32'd2));
    emit(i_type(7'h13, 3'b000, 5'd7, 5'd0, 32'd5));
    branch_pair(3'b000, 5'd6, 5'd6, 5'd6, 5'd7);
    branch_pair(3'b001, 5'd6, 5'd7, 5'd6, 5'd6);
    branch_pair(3'b100, 5'd6, 5'd7, 5'd7, 5'd6);
    branch_pair(3'b101, 5'd7, 5'd6, 5'd6, 5'd7);
    branch_pair(3'b110, 5'd7, 5'd6, 5'd6, 5'd7);
    branch_pair(3'b111, 5'd6, 5'd7, 5'd7, 5'd6);
    emit(s_type(5'd21, 5'd0, 32'h300));
    expect_store(2'd2, 32'h300, 32'd6);  // one count per not-taken branch
    // Store, load back, store the loaded word plus one
    emit(u_type(7'h37, 5'd8, 20'hCAFE1));
    emit(i_type(7'h13, 3'b000, 5'd8, 5'd8, 32'h234));
    emit(s_type(5'd8, 5'd0, 32'h400));
    emit(i_type(7'h03, 3'b010, 5'd9, 5'd0, 32'h400));
    emit(i_type(7'h13, 3'b000, 5'd9, 5'd9, 32'd1));
    emit(s_type(5'd9, 5'd0, 32'h404));
    emit(j_type(5'd0, 32'd0));
    expect_store(2'd3, 32'h400, 32'hCAFE_1234);
    expect_store(2'd3, 32'h404, 32'hCAFE_1235);
endtask

`endif

//--- dv/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

    // About four times the 80-cycle program run
    localparam int cycle_limit = 300;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_wen;
    logic        dmem_ren;
    logic [31:0] dmem_rdata;

    logic [31:0] rom [128];
    logic [31:0] ram [1024];
    logic [6:0]  n_instr;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [1:0]  exp_sect [$];
    string       sect_name [4] = '{"arith", "upper_jump", "branch", "memory"};
    int          sect_err [4] = '{0, 0, 0, 0};
    int          check_idx = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    `include "tb_programs.svh"

    rv_core DUT (
        .clk, .rst_n, .imem_addr, .imem_data,
        .dmem_addr, .dmem_wdata, .dmem_wen, .dmem_ren, .dmem_rdata
    );

    // ------------------------------
    // Clock and memory models
    // ------------------------------
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    assign imem_data  = rom[imem_addr[8:2]];
    assign dmem_rdata = ram[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            ram[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    task automatic record_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic report_section(input logic [1:0] s);
        if (sect_err[s] == 0) begin
            $display("test %s: passed", sect_name[s]);
        end else begin
            $display("test %s: failed with %0d errors", sect_name[s], sect_err[s]);
        end
    endtask

    task automatic check_store();
        logic [1:0] s;
        if (check_idx >= exp_addr.size()) begin
            record_failure($sformatf("unexpected store of %h to %h after the program ended",
                dmem_wdata, dmem_addr));
        end else begin
            s = exp_sect[check_idx];
            checks++;
            assert (dmem_addr == exp_addr[check_idx] && dmem_wdata == exp_data[check_idx])
            else begin
                errors++;
                sect_err[s] = sect_err[s] + 1;
                $display("ERROR %s: expected %h at %h, actual %h at %h", sect_name[s],
                    exp_data[check_idx], exp_addr[check_idx], dmem_wdata, dmem_addr);
            end
            check_idx++;
            if (check_idx == exp_addr.size() || exp_sect[check_idx] != s) begin
                report_section(s);
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && dmem_wen) begin
            check_store();
        end
    end

    // ------------------------------
    // Protocol checks
    // ------------------------------
    reset_quiet: assert property (@(negedge clk) !rst_n |-> !dmem_wen)
        else record_failure("dmem_wen went high while reset was asserted");

    first_fetch: assert property (@(negedge clk) $rose(rst_n) |-> imem_addr == 32'h0)
        else record_failure($sformatf("ERROR reset: expected %h, actual %h",
            32'h0, imem_addr));

    no_poison: assert property (@(negedge clk) disable iff (!rst_n)
        dmem_wen |-> dmem_wdata != poison)
        else record_failure($sformatf("skipped instruction stored the poison word to %h",
            dmem_addr));

    ren_on_load: assert property (@(negedge clk) disable iff (!rst_n)
        dmem_ren == (imem_data[6:0] == 7'b0000011))
        else record_failure("dmem_ren does not match whether the instruction is a load");

    // Branch, JAL and JALR are the only flow changes
    seq_flow: assert property (@(negedge clk) disable iff (!rst_n)
        !(imem_data[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111})
        |=> imem_addr == $past(imem_addr) + 32'd4)
        else record_failure("fetch address did not advance by 4 after a plain instruction");

    // The odd JALR target only lands on a word once bit 0 is cleared
    fetch_aligned: assert property (@(negedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else record_failure("fetch address is not word aligned");

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        load_program();
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        while (check_idx < exp_addr.size() && cycles < cycle_limit) begin
            @(posedge clk);
        end
        if (check_idx < exp_addr.size()) begin
            $display("timeout: program did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
        end else begin
            $display("store checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; (
    input  wire logic [xlen-1:0]     a,
    input  wire logic [xlen-1:0]     b,
    input  wire logic [alu_op_w-1:0] alu_op,
    input  wire logic                comp_flag,
    output logic [xlen-1:0]          result
);

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];

    // comp_flag picks the unsigned compare
    assign less = comp_flag ? (a < b) : ($signed(a) < $signed(b));

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (alu_op)
            alu_sub: result = a - b;
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            alu_sra: result = $signed(a) >>> shamt;
            alu_xor: result = a ^ b;
            alu_or:  result = a | b;
            alu_and: result = a & b;
            alu_cmp: result = {{(xlen-1){1'b0}}, less};
            alu_neq: result = {{(xlen-1){1'b0}}, a != b};
            default: result = a + b;
        endcase
    end

    // Branch logic in pc_unit relies on a clean 0/1 flag word
    always_comb begin
        if (alu_op == alu_cmp || alu_op == alu_neq) begin
            assert (result[xlen-1:1] == '0)
                else $error("alu: flag result has upper bits set");
        end
    end

endmodule

`default_nettype wire

//--- rtl/control.sv
`timescale 1ns/10ps
`default_nettype none

module control import rv_pkg::*; (
    input  wire logic [6:0]          opcode,
    input  wire logic [2:0]          funct3,
    input  wire logic [6:0]          funct7,
    output logic                     reg_wen,
    output logic                     mem_wen,
    output logic                     mem_ren,
    output logic                     jump_flag,
    output logic                     branch_flag,
    output logic                     rs2_flag,
    output logic                     comp_flag,
    output logic                     inv_flag,
    output logic [alu_op_w-1:0]      alu_op,
    output logic [2:0]               imm_kind,
    output logic [1:0]               src1_sel
);

    logic arith;

    assign arith = (opcode == op_reg) || (opcode == op_imm);

    // ------------------------------
    // Strobes and selects per class
    // ------------------------------
    always_comb begin
        reg_wen     = 1'b0;
        mem_wen     = 1'b0;
        mem_ren     = 1'b0;
        jump_flag   = 1'b0;
        branch_flag = 1'b0;
        rs2_flag    = 1'b0;
        imm_kind    = imm_12i;
        src1_sel    = src_reg;
        case (opcode)
            op_load: begin
                reg_wen = 1'b1;
                mem_ren = 1'b1;
            end
            op_store: begin
                mem_wen  = 1'b1;
                imm_kind = imm_12s;
            end
            op_imm: begin
                reg_wen = 1'b1;
                // Shift-immediates carry only shamt
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_kind = imm_5u;
                end
            end
            op_reg: begin
                reg_wen  = 1'b1;
                rs2_flag = 1'b1;
            end
            op_branch: begin
                branch_flag = 1'b1;
                rs2_flag    = 1'b1;
                imm_kind    = imm_13b;
            end
            op_lui: begin
                reg_wen  = 1'b1;
                imm_kind = imm_20u;
                src1_sel = src_zero;
            end
            op_auipc: begin
                reg_wen  = 1'b1;
                imm_kind = imm_20u;
                src1_sel = src_pc;
            end
            op_jal: begin
                reg_wen   = 1'b1;
                jump_flag = 1'b1;
                imm_kind  = imm_21j;
                src1_sel  = src_pc;
            end
            op_jalr: begin
                reg_wen   = 1'b1;
                jump_flag = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Unsigned compares: SLTU, SLTIU, BLTU, BGEU
    assign comp_flag = (arith && funct3 == 3'b011)
                    || (opcode == op_branch && funct3[2:1] == 2'b11);

    // BEQ, BGE, BGEU take the branch on a zero ALU flag
    assign inv_flag = (opcode == op_branch)
                   && (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);

    // ALU operation
    always_comb begin
        alu_op = alu_add;
        if (arith) begin
            case (funct3)
                3'b000:         alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                3'b001:         alu_op = alu_sll;
                3'b010, 3'b011: alu_op = alu_cmp;
                3'b100:         alu_op = alu_xor;
                3'b101:         alu_op = funct7[5] ? alu_sra : alu_srl;
                3'b110:         alu_op = alu_or;
                default:        alu_op = alu_and;
            endcase
        end else if (opcode == op_branch) begin
            // BEQ/BNE test equality, the rest compare
            alu_op = funct3[2] ? alu_cmp : alu_neq;
        end
    end

    always_comb begin
        assert (!(mem_wen && reg_wen))
            else $error("control: store also requests a register write");
    end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen import rv_pkg::*; (
    input  wire logic [xlen-1:0] instr,
    input  wire logic [2:0]      imm_kind,
    output logic [xlen-1:0]      imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_kind)
            imm_12s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 implied zero
            imm_13b: imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_20u: imm = {instr[31:12], 12'b0};
            imm_21j: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // Shift amount, never sign extended
            imm_5u:  imm = {27'b0, instr[24:20]};
            default: imm = {{20{sign}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit import rv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [xlen-1:0] alu_result,
    input  wire logic            jump_flag,
    input  wire logic            branch_flag,
    input  wire logic            inv_flag,
    output logic [xlen-1:0]      pc,
    output logic [xlen-1:0]      pc_plus4
);

    logic            taken;
    logic [xlen-1:0] next_pc;

    assign pc_plus4 = pc + 32'd4;

    // ALU flag in bit 0, inverted for BEQ/BGE/BGEU
    assign taken = branch_flag && (alu_result[0] != inv_flag);

    always_comb begin
        if (jump_flag) begin
            next_pc = {alu_result[xlen-1:1], 1'b0};
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            wen,
    input  wire logic [4:0]      rs1_addr,
    input  wire logic [4:0]      rs2_addr,
    input  wire logic [4:0]      rd_addr,
    input  wire logic [xlen-1:0] rd_data,
    output logic [xlen-1:0]      rs1_data,
    output logic [xlen-1:0]      rs2_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 stays zero through reset clearing and write masking
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr == 5'd0 |-> rs1_data == '0) and (rs2_addr == 5'd0 |-> rs2_data == '0));

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    output logic [xlen-1:0]      imem_addr,
    input  wire logic [xlen-1:0] imem_data,
    output logic [xlen-1:0]      dmem_addr,
    output logic [xlen-1:0]      dmem_wdata,
    output logic                 dmem_wen,
    output logic                 dmem_ren,
    input  wire logic [xlen-1:0] dmem_rdata
);

    logic                reg_wen;
    logic                mem_wen;
    logic                mem_ren;
    logic                jump_flag;
    logic                branch_flag;
    logic                rs2_flag;
    logic                comp_flag;
    logic                inv_flag;
    logic [alu_op_w-1:0] alu_op;
    logic [2:0]          imm_kind;
    logic [1:0]          src1_sel;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
    logic [xlen-1:0]     op_a;
    logic [xlen-1:0]     op_b;
    logic [xlen-1:0]     alu_result;
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     pc_plus4;
    logic [xlen-1:0]     wb_data;

    control u_control (
        .opcode(imem_data[6:0]), .funct3(imem_data[14:12]), .funct7(imem_data[31:25]),
        .reg_wen, .mem_wen, .mem_ren, .jump_flag, .branch_flag, .rs2_flag,
        .comp_flag, .inv_flag, .alu_op, .imm_kind, .src1_sel
    );

    imm_gen u_imm_gen (.instr(imem_data), .imm_kind, .imm);

    reg_file u_reg_file (
        .clk, .rst_n, .wen(reg_wen && rst_n),
        .rs1_addr(imem_data[19:15]), .rs2_addr(imem_data[24:20]), .rd_addr(imem_data[11:7]),
        .rd_data(wb_data), .rs1_data, .rs2_data
    );

    // ------------------------------
    // Operand select and execute
    // ------------------------------
    always_comb begin
        case (src1_sel)
            src_pc:   op_a = pc;
            src_zero: op_a = '0;
            default:  op_a = rs1_data;
        endcase
    end

    assign op_b = rs2_flag ? rs2_data : imm;

    alu u_alu (.a(op_a), .b(op_b), .alu_op, .comp_flag, .result(alu_result));

    pc_unit u_pc_unit (
        .clk, .rst_n, .imm, .alu_result, .jump_flag, .branch_flag, .inv_flag, .pc, .pc_plus4
    );

    // Write-back prefers the link address, then load data, then ALU
    assign wb_data = jump_flag ? pc_plus4 : (mem_ren ? dmem_rdata : alu_result);

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_wen   = mem_wen && rst_n;
    assign dmem_ren   = mem_ren;

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ------------------------------
    // Data path
    // ------------------------------
    localparam int xlen = 32;
    localparam int alu_op_w = 4;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

    // ------------------------------
    // RV32I major opcodes
    // ------------------------------
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // ------------------------------
    // ALU operations
    // ------------------------------
    localparam logic [alu_op_w-1:0] alu_add = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_w-1:0] alu_sll = 4'd2;
    localparam logic [alu_op_w-1:0] alu_srl = 4'd3;
    localparam logic [alu_op_w-1:0] alu_sra = 4'd4;
    localparam logic [alu_op_w-1:0] alu_xor = 4'd5;
    localparam logic [alu_op_w-1:0] alu_or  = 4'd6;
    localparam logic [alu_op_w-1:0] alu_and = 4'd7;
    // Less-than, signedness from comp_flag
    localparam logic [alu_op_w-1:0] alu_cmp = 4'd8;
    localparam logic [alu_op_w-1:0] alu_neq = 4'd9;

    // Immediate kinds
    localparam logic [2:0] imm_12i = 3'd0;
    localparam logic [2:0] imm_12s = 3'd1;
    localparam logic [2:0] imm_13b = 3'd2;
    localparam logic [2:0] imm_20u = 3'd3;
    localparam logic [2:0] imm_21j = 3'd4;
    localparam logic [2:0] imm_5u  = 3'd5;

    // Operand 1 sources
    localparam logic [1:0] src_reg  = 2'd0;
    localparam logic [1:0] src_pc   = 2'd1;
    localparam logic [1:0] src_zero = 2'd2;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

//--- tb.f
+incdir+dv
rtl/rv_pkg.sv
rtl/control.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/rv_core.sv
dv/tb_rv_core.sv
